// File: include/fs_macros.svh
/* forth stack processor sizing
   data path, program space, stack depth and emit credits */
`ifndef FS_MACROS_SVH
`define FS_MACROS_SVH

// data path width, one cell
`define FS_DSZ      32

// program address width, 256 opcode bytes
`define FS_ASZ      8

// stack entries kept below tos
`define FS_DEPTH    16

// emit items in flight before a credit comes back
`define FS_CREDITS  4

`endif

// File: project.f
+incdir+include
source/fs_isa_pkg.sv
source/fs_bus_pkg.sv
source/op_mem.sv
source/data_stack.sv
source/exec.sv
source/forth_core.sv
testbench/tb_forth_core.sv

// File: run.sh
#!/usr/bin/env bash
# build the forth core testbench with verilator, run it, grade the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_forth_core -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_forth_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: source/data_stack.sv
/* data stack below tos
   register array with push, pop and replace, sticky bound flags */
`timescale 1ns/1ps
`default_nettype none

`include "fs_macros.svh"

module data_stack (
    input  logic                              clk,
    input  logic                              rst,
    input  fs_bus_pkg::stk_req_t              req,
    output logic [`FS_DSZ-1:0]                nos,    // top entry, combinational
    output logic [$clog2(`FS_DEPTH+1)-1:0]    depth,  // entries held, 0 to FS_DEPTH
    output logic                              ovf,    // sticky
    output logic                              unf     // sticky
);

    localparam int IW = $clog2(`FS_DEPTH);

    logic [`FS_DSZ-1:0] mem [`FS_DEPTH];
    logic [IW-1:0]      top_idx;  // slot of nos
    logic [IW-1:0]      free_idx; // slot a push lands in
    logic               full;
    logic               empty;
    logic               do_push;
    logic               do_pop;
    logic               do_repl;

    assign top_idx  = depth[IW-1:0] - 1'b1;  // wraps on empty, contents undefined then
    assign free_idx = depth[IW-1:0];
    assign full     = (depth == `FS_DEPTH);
    assign empty    = (depth == '0);
    assign do_repl  = req.push && req.pop;
    assign do_push  = req.push && !req.pop;
    assign do_pop   = req.pop && !req.push;

    assign nos = mem[top_idx];

    // storage, writes dropped when out of bounds
    always_ff @(posedge clk) begin
        if (do_repl && !empty) begin
            mem[top_idx] <= req.data;  // swap rewrites nos in place
        end
        else if (do_push && !full) begin
            mem[free_idx] <= req.data;
        end
    end

    // pointer and flags
    always_ff @(posedge clk) begin
        if (rst) begin
            depth <= '0;
            ovf   <= 1'b0;
            unf   <= 1'b0;
        end
        else begin
            if (do_push) begin
                if (full) ovf <= 1'b1;       // depth held at the limit
                else      depth <= depth + 1'b1;
            end
            else if (do_pop) begin
                if (empty) unf <= 1'b1;      // depth held at zero
                else       depth <= depth - 1'b1;
            end
            else if (do_repl && empty) begin
                unf <= 1'b1;                 // nothing to replace
            end
        end
    end

    // a push lands in the slot that becomes nos
    a_push_top : assert property (@(posedge clk) disable iff (rst)
        (do_push && !full) |=> (nos == $past(req.data)))
        else $error("data_stack: pushed value not on top");

    // a replace rewrites nos in place
    a_replace_top : assert property (@(posedge clk) disable iff (rst)
        (do_repl && !empty) |=> (nos == $past(req.data)))
        else $error("data_stack: replace did not rewrite nos");

endmodule : data_stack

`default_nettype wire

// File: source/exec.sv
/* execution unit
   two cycle fetch and execute sequencer, tos register, emit credits */
`timescale 1ns/1ps
`default_nettype none

`include "fs_macros.svh"

module exec (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  run,         // one cycle start pulse
    output logic [`FS_ASZ-1:0]    rd_addr,
    input  fs_isa_pkg::instr_u    rd_data,     // valid in the execute cycle
    output fs_bus_pkg::stk_req_t  stk,
    input  logic [`FS_DSZ-1:0]    nos,
    output fs_bus_pkg::emit_t     emit,
    input  logic                  credit_ret,  // consumer finished one item
    output logic [`FS_DSZ-1:0]    tos,
    output logic                  busy,
    output logic                  done
);

    import fs_isa_pkg::*;

    localparam int CW = $clog2(`FS_CREDITS + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,  // ip on the memory address
        S_EXEC,   // byte arrives, decode and update
        S_DONE    // halted, wait for next run
    } state_e;

    state_e              state;
    state_e              state_nxt;
    logic [`FS_ASZ-1:0]  ip;
    logic [`FS_ASZ-1:0]  ip_nxt;
    logic [`FS_DSZ-1:0]  tos_nxt;
    logic [CW-1:0]       credits;     // items the consumer can still take
    logic                has_credit;
    logic                send;        // emit leaves this cycle

    // forth truth value, 1 or 0
    function automatic logic [`FS_DSZ-1:0] flag(input logic b);
        return {{(`FS_DSZ-1){1'b0}}, b};
    endfunction

    // words that pop nos and fold it into tos
    function automatic logic [`FS_DSZ-1:0] binop(
        input opcode_e            op,
        input logic [`FS_DSZ-1:0] n,
        input logic [`FS_DSZ-1:0] t
    );
        logic signed [`FS_DSZ-1:0] sn;
        logic signed [`FS_DSZ-1:0] st;
        sn = n;
        st = t;
        case (op)
            _PLUS:   return n + t;
            _MINUS:  return n - t;
            _MUL:    return n * t;  // low cell, sign does not matter
            _AND:    return n & t;
            _OR:     return n | t;
            _XOR:    return n ^ t;
            _MAX:    return (sn > st) ? n : t;
            _MIN:    return (sn < st) ? n : t;
            _EQ:     return flag(n == t);
            _LT:     return flag(sn < st);
            _GT:     return flag(sn > st);
            default: return t;
        endcase
    endfunction

    assign rd_addr    = ip;  // registered read gives the byte next cycle
    assign busy       = (state == S_FETCH) || (state == S_EXEC);
    assign done       = (state == S_DONE);
    assign has_credit = (credits != '0);

    always_comb begin
        state_nxt = state;
        ip_nxt    = ip;
        tos_nxt   = tos;
        stk       = '0;
        emit      = '0;
        send      = 1'b0;
        unique case (state)
            S_IDLE, S_DONE: begin
                if (run) begin
                    state_nxt = S_FETCH;
                    ip_nxt    = '0;  // programs start at byte 0
                end
            end
            S_FETCH: state_nxt = S_EXEC;
            S_EXEC: begin
                state_nxt = S_FETCH;
                ip_nxt    = ip + 1'b1;
                if (rd_data.lit.is_lit) begin
                    stk.push = 1'b1;  // spill old tos
                    stk.data = tos;
                    tos_nxt  = {{(`FS_DSZ-7){1'b0}}, rd_data.lit.value};
                end
                else begin
                    case (rd_data.op)
                        _DUP: begin
                            stk.push = 1'b1;
                            stk.data = tos;
                        end
                        _DROP: begin
                            stk.pop = 1'b1;
                            tos_nxt = nos;
                        end
                        _OVER: begin
                            stk.push = 1'b1;  // a b -- a b a
                            stk.data = tos;
                            tos_nxt  = nos;
                        end
                        _SWAP: begin
                            stk.push = 1'b1;  // replace nos with old tos
                            stk.pop  = 1'b1;
                            stk.data = tos;
                            tos_nxt  = nos;
                        end
                        _PLUS, _MINUS, _MUL, _AND, _OR, _XOR,
                        _MAX, _MIN, _EQ, _LT, _GT: begin
                            stk.pop = 1'b1;
                            tos_nxt = binop(rd_data.op, nos, tos);
                        end
                        _NEG: tos_nxt = ~tos;
                        _ZEQ: tos_nxt = flag(tos == '0);
                        _ZLT: tos_nxt = flag(tos[`FS_DSZ-1]);  // sign bit
                        _EMIT: begin
                            if (has_credit) begin
                                send      = 1'b1;
                                emit.data = tos;
                                stk.pop   = 1'b1;  // emit consumes tos
                                tos_nxt   = nos;
                            end
                            else begin
                                state_nxt = S_EXEC;  // stall, byte stays on rd_data
                                ip_nxt    = ip;
                            end
                        end
                        _HALT: begin
                            state_nxt = S_DONE;
                            ip_nxt    = ip;
                        end
                        default: tos_nxt = tos;  // nop and unused codes
                    endcase
                end
            end
            default: state_nxt = S_IDLE;
        endcase
        emit.valid = send;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_IDLE;
            ip      <= '0;
            tos     <= '0;
            credits <= CW'(`FS_CREDITS);
        end
        else begin
            state   <= state_nxt;
            ip      <= ip_nxt;
            tos     <= tos_nxt;
            credits <= credits + credit_ret - send;  // both in one cycle cancel
        end
    end

    // the byte being decoded was loaded by the host
    a_known_instr : assert property (@(posedge clk) disable iff (rst)
        (state == S_EXEC) |-> !$isunknown(rd_data))
        else $error("exec: unknown program byte in execute");

    // consumer must not return more than it was given
    a_credit_bound : assert property (@(posedge clk) disable iff (rst)
        credits <= `FS_CREDITS)
        else $error("exec: credit count above FS_CREDITS");

endmodule : exec

`default_nettype wire

// File: source/forth_core.sv
/* forth stack processor top
   program memory, data stack and execution unit */
`timescale 1ns/1ps
`default_nettype none

`include "fs_macros.svh"

module forth_core (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              run,
    input  logic                              prog_we,    // host load, idle only
    input  logic [`FS_ASZ-1:0]                prog_addr,
    input  logic [7:0]                        prog_data,
    input  logic                              credit_ret,
    output fs_bus_pkg::emit_t                 emit,
    output logic [`FS_DSZ-1:0]                tos,
    output logic [$clog2(`FS_DEPTH+1)-1:0]    depth,
    output logic                              ovf,
    output logic                              unf,
    output logic                              busy,
    output logic                              done
);

    import fs_isa_pkg::*;
    import fs_bus_pkg::*;

    logic [`FS_ASZ-1:0] rd_addr;
    instr_u             instr;    // prefetched program byte
    stk_req_t           stk_req;  // exec to stack
    logic [`FS_DSZ-1:0] nos;

    op_mem u_op_mem (
        .clk     (clk),
        .we      (prog_we),
        .wr_addr (prog_addr),
        .wr_data (prog_data),
        .rd_addr (rd_addr),
        .rd_data (instr)
    );

    data_stack u_data_stack (
        .clk   (clk),
        .rst   (rst),
        .req   (stk_req),
        .nos   (nos),
        .depth (depth),
        .ovf   (ovf),
        .unf   (unf)
    );

    exec u_exec (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .rd_addr    (rd_addr),
        .rd_data    (instr),
        .stk        (stk_req),
        .nos        (nos),
        .emit       (emit),
        .credit_ret (credit_ret),
        .tos        (tos),
        .busy       (busy),
        .done       (done)
    );

endmodule : forth_core

`default_nettype wire

// File: source/fs_bus_pkg.sv
/* forth core bus types
   stack request from the execution unit and the emit channel */
`default_nettype none

`include "fs_macros.svh"

package fs_bus_pkg;

    // push alone spills, pop alone drops, both replace top entry (swap)
    typedef struct packed {
        logic               push;
        logic               pop;
        logic [`FS_DSZ-1:0] data;  // value to store on push or replace
    } stk_req_t;

    // one item per valid cycle, paced by credits
    typedef struct packed {
        logic               valid;
        logic [`FS_DSZ-1:0] data;
    } emit_t;

endpackage : fs_bus_pkg

`default_nettype wire

// File: source/fs_isa_pkg.sv
/* forth instruction set
   opcode encoding and the two views of one program byte */
`default_nettype none

package fs_isa_pkg;

    // top bit clear on every opcode, set means short literal
    typedef enum logic [7:0] {
        _NOP   = 8'h00,
        _DUP   = 8'h01,
        _DROP  = 8'h02,
        _OVER  = 8'h03,
        _SWAP  = 8'h04,
        _PLUS  = 8'h05,  // nos + tos
        _MINUS = 8'h06,  // nos - tos
        _MUL   = 8'h07,  // low cell of the product
        _AND   = 8'h08,
        _OR    = 8'h09,
        _XOR   = 8'h0a,
        _NEG   = 8'h0b,  // bitwise invert
        _MAX   = 8'h0c,  // signed
        _MIN   = 8'h0d,  // signed
        _ZEQ   = 8'h0e,  // 0=
        _ZLT   = 8'h0f,  // 0<
        _EQ    = 8'h10,
        _LT    = 8'h11,  // nos < tos, signed
        _GT    = 8'h12,  // nos > tos, signed
        _EMIT  = 8'h13,
        _HALT  = 8'h14
    } opcode_e;

    // short literal, value zero-extended on push
    typedef struct packed {
        logic       is_lit;
        logic [6:0] value;
    } lit_byte_t;

    // same byte read either way, is_lit picks the view
    typedef union packed {
        opcode_e   op;
        lit_byte_t lit;
    } instr_u;

endpackage : fs_isa_pkg

`default_nettype wire

// File: source/op_mem.sv
/* opcode memory
   byte program store, host write port, registered read for prefetch */
`timescale 1ns/1ps
`default_nettype none

`include "fs_macros.svh"

module op_mem (
    input  logic                clk,
    input  logic                we,       // host load strobe
    input  logic [`FS_ASZ-1:0]  wr_addr,
    input  logic [7:0]          wr_data,
    input  logic [`FS_ASZ-1:0]  rd_addr,  // ip from exec
    output fs_isa_pkg::instr_u  rd_data   // byte for the next execute cycle
);

    localparam int WORDS = 2 ** `FS_ASZ;

    logic [7:0] mem [WORDS];  // program bytes

    // host side, only while the core is idle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];  // plain byte, decoded by exec
    end

endmodule : op_mem

`default_nettype wire

// File: testbench/tb_forth_core.sv
/* forth core testbench
   random programs, reference stack model, credit consumer */
`timescale 1ns/1ps
`default_nettype none

`include "fs_macros.svh"

module tb_forth_core;

    import fs_isa_pkg::*;
    import fs_bus_pkg::*;

    logic                              clk = 1'b0;
    logic                              rst;
    logic                              run;
    logic                              prog_we;
    logic [`FS_ASZ-1:0]                prog_addr;
    logic [7:0]                        prog_data;
    logic                              credit_ret = 1'b0;  // driven by the consumer
    emit_t                             emit;
    logic [`FS_DSZ-1:0]                tos;
    logic [$clog2(`FS_DEPTH+1)-1:0]    depth;
    logic                              ovf;
    logic                              unf;
    logic                              busy;
    logic                              done;

    logic [31:0] gen_state = 32'd58334;   // program generator
    logic [31:0] cons_state = ~32'd58334; // consumer delays, own stream
    logic [7:0]  prog_q[$];
    logic [31:0] exp_q[$];                // model emit stream
    logic [31:0] got_q[$];                // what the dut sent
    logic [31:0] exp_tos;
    int          exp_depth;
    int          pend[$];                 // cycle each credit goes back
    int          cyc = 0;
    int          outstanding = 0;
    int          max_out = 0;
    bit          slow = 1'b0;             // fixed long credit delay
    int          errors = 0;
    int          tests = 0;
    int          failed = 0;
    int          err_mark;
    string       cur_test;

    always #5 clk = ~clk;

    forth_core dut (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .credit_ret (credit_ret),
        .emit       (emit),
        .tos        (tos),
        .depth      (depth),
        .ovf        (ovf),
        .unf        (unf),
        .busy       (busy),
        .done       (done)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        gen_state = xorshift(gen_state);
        return gen_state;
    endfunction

    // depth after byte b, -1 when b is not legal at depth d
    function automatic int next_depth(input logic [7:0] b, input int d);
        if (b[7]) return (d < 14) ? d + 1 : -1;  // literal spills tos
        case (b)
            _DUP:  return (d < 14) ? d + 1 : -1;
            _OVER: return (d >= 1 && d < 14) ? d + 1 : -1;
            _SWAP: return (d >= 1) ? d : -1;
            _DROP, _PLUS, _MINUS, _MUL, _AND, _OR, _XOR, _MAX, _MIN,
            _EQ, _LT, _GT, _EMIT: return (d >= 1) ? d - 1 : -1;
            default: return d;  // unary words and nop
        endcase
    endfunction

    // credit returning consumer, samples dut outputs on the rising edge
    always @(posedge clk) begin
        cyc++;
        if (rst) begin
            pend = {};
            got_q = {};
            outstanding = 0;
            max_out = 0;
            credit_ret <= 1'b0;
        end
        else begin
            if (credit_ret) outstanding--;  // dut counts it on this edge
            if (emit.valid) begin
                got_q.push_back(emit.data);
                outstanding++;
                cons_state = xorshift(cons_state);
                pend.push_back(cyc + (slow ? 6 : int'(cons_state % 7)));
            end
            if (outstanding > max_out) max_out = outstanding;
            assert (outstanding <= `FS_CREDITS)
            else begin
                $display("credit overrun in %s: %0d items outstanding", cur_test, outstanding);
                errors++;
            end
            if (pend.size() != 0 && pend[0] <= cyc) begin
                credit_ret <= 1'b1;  // one credit per cycle
                void'(pend.pop_front());
            end
            else credit_ret <= 1'b0;
        end
    end

    task automatic build_program(input int len, input bit stack_only);
        logic [31:0] r;
        logic [7:0]  b;
        int          d;
        int          nd;
        prog_q = {};
        d = 0;
        for (int k = 0; k < len * 8 && prog_q.size() < len; k++) begin
            r = next_rand();
            if (stack_only) b = (r % 5 == 0) ? {1'b1, r[14:8]} : 8'(r % 5);  // 1..4 dup..swap
            else if (r[3:0] < 4) b = {1'b1, r[14:8]};
            else begin
                b = 8'((r >> 16) % 21);
                if (b == _HALT) b = 8'h55;  // unused code, runs as nop
            end
            nd = next_depth(b, d);
            if (nd >= 0) begin
                prog_q.push_back(b);
                d = nd;
            end
        end
        prog_q.push_back(_HALT);
    endtask

    // operand pairs through one alu word, each result emitted
    task automatic build_alu_program(input int n);
        logic [31:0] r;
        logic [7:0]  op;
        prog_q = {};
        repeat (n) begin
            r = next_rand();
            op = 8'(5 + r % 14);  // plus .. gt
            prog_q.push_back({1'b1, r[14:8]});
            if (r[20]) prog_q.push_back(_NEG);  // negative operand
            if (op != _NEG && op != _ZEQ && op != _ZLT) begin
                prog_q.push_back({1'b1, r[27:21]});
                if (r[28]) prog_q.push_back(_NEG);
            end
            prog_q.push_back(op);
            prog_q.push_back(_EMIT);
        end
        prog_q.push_back(_HALT);
    endtask

    // reference forth machine over prog_q
    task automatic model_program();
        logic [31:0] t;
        logic [31:0] n;
        logic [31:0] s[$];
        logic [7:0]  b;
        bit          halted;
        t = '0;
        exp_q = {};
        halted = 1'b0;
        foreach (prog_q[i]) begin
            b = prog_q[i];
            if (halted) continue;
            if (b[7]) begin
                s.push_back(t);
                t = {25'd0, b[6:0]};
            end
            else if (b inside {_PLUS, _MINUS, _MUL, _AND, _OR, _XOR, _MAX, _MIN,
                               _EQ, _LT, _GT}) begin
                n = s.pop_back();  // second operand below tos
                case (b)
                    _PLUS:  t = n + t;
                    _MINUS: t = n - t;
                    _MUL:   t = n * t;
                    _AND:   t = n & t;
                    _OR:    t = n | t;
                    _XOR:   t = n ^ t;
                    _MAX:   t = ($signed(n) > $signed(t)) ? n : t;
                    _MIN:   t = ($signed(n) < $signed(t)) ? n : t;
                    _EQ:    t = (n == t) ? 32'd1 : 32'd0;
                    _LT:    t = ($signed(n) < $signed(t)) ? 32'd1 : 32'd0;
                    default: t = ($signed(n) > $signed(t)) ? 32'd1 : 32'd0;
                endcase
            end
            else begin
                case (b)
                    _DUP:  s.push_back(t);
                    _DROP: t = s.pop_back();
                    _OVER: begin
                        n = s[$];
                        s.push_back(t);
                        t = n;
                    end
                    _SWAP: begin
                        n = s.pop_back();
                        s.push_back(t);
                        t = n;
                    end
                    _NEG:  t = ~t;
                    _ZEQ:  t = (t == 0) ? 32'd1 : 32'd0;
                    _ZLT:  t = t[31] ? 32'd1 : 32'd0;
                    _EMIT: begin
                        exp_q.push_back(t);
                        t = s.pop_back();
                    end
                    _HALT: halted = 1'b1;
                    default: ;  // nop
                endcase
            end
        end
        exp_tos = t;
        exp_depth = s.size();
    endtask

    task automatic apply_reset();
        rst <= 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
    endtask

    // reset, load prog_q, pulse run, wait for done
    task automatic start_and_wait();
        int n;
        apply_reset();
        foreach (prog_q[i]) begin
            prog_we <= 1'b1;
            prog_addr <= `FS_ASZ'(i);
            prog_data <= prog_q[i];
            @(posedge clk);
        end
        prog_we <= 1'b0;
        run <= 1'b1;
        @(posedge clk);
        run <= 1'b0;
        for (n = 0; n < 3000 && !done; n++) @(posedge clk);
        assert (done === 1'b1)
        else begin
            $display("timeout in %s: done never rose after run", cur_test);
            errors++;
        end
        if (done === 1'b1) check_value("busy at done", 0, busy);  // busy falls with done
    endtask

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else begin
            $display("error %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_emits();
        check_value("emit count", exp_q.size(), got_q.size());
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            check_value($sformatf("emit %0d", i), exp_q[i], got_q[i]);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = errors;
        tests++;
    endtask

    task automatic end_test();
        if (errors == err_mark) $display("test %s: pass", cur_test);
        else begin
            $display("test %s: FAIL with %0d errors", cur_test, errors - err_mark);
            failed++;
        end
    endtask

    initial begin
        rst <= 1'b1;
        run <= 1'b0;
        prog_we <= 1'b0;
        prog_addr <= '0;
        prog_data <= '0;

        begin_test("reset state");
        apply_reset();
        check_value("done", 0, done);
        check_value("busy", 0, busy);
        check_value("emit valid", 0, emit.valid);
        check_value("depth", 0, 32'(depth));
        end_test();

        begin_test("stack words");
        repeat (10) begin
            build_program(6 + int'(next_rand() % 15), 1'b1);
            model_program();
            start_and_wait();
            check_value("tos", exp_tos, tos);
            check_value("depth", exp_depth, 32'(depth));
        end
        end_test();

        begin_test("alu and compare");
        repeat (4) begin
            build_alu_program(12);
            model_program();
            start_and_wait();
            check_emits();
        end
        end_test();

        begin_test("credit flow");
        slow = 1'b1;  // every credit held 6 cycles
        prog_q = {};
        repeat (10) prog_q.push_back({1'b1, 7'(next_rand())});
        repeat (10) prog_q.push_back(_EMIT);
        prog_q.push_back(_HALT);
        model_program();
        start_and_wait();
        check_emits();
        check_value("peak outstanding", `FS_CREDITS, max_out);
        slow = 1'b0;
        end_test();

        begin_test("random programs");
        repeat (40) begin
            build_program(10 + int'(next_rand() % 31), 1'b0);
            model_program();
            start_and_wait();
            check_emits();
            check_value("tos", exp_tos, tos);
            check_value("depth", exp_depth, 32'(depth));
            check_value("ovf", 0, ovf);
            check_value("unf", 0, unf);
        end
        end_test();

        begin_test("underflow");
        prog_q = {};
        prog_q.push_back(_DROP);  // nothing below tos
        prog_q.push_back(_HALT);
        start_and_wait();
        assert (unf === 1'b1)
        else begin
            $display("underflow flag stayed low after a drop on an empty stack");
            errors++;
        end
        end_test();

        $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) $display("No errors");
        else $display("Errors found");
        $finish;
    end

endmodule : tb_forth_core

`default_nettype wire
